//--- rtl/rx_pkg.sv
/*
  rx_pkg: shared widths, limits, BAR translation tables and types
  of the PCIe receive request controller
*/
package rx_pkg;

  localparam int DATA_W        = 64;
  localparam int BE_W          = 8;
  localparam int NUM_BARS      = 6;
  localparam int FIFO_DEPTH    = 16;
  localparam int FIFO_CNT_W    = 5;
  localparam int READY_LIMIT   = 10;  // 3 beats in flight plus 3 spare
  localparam int MAX_RD_DW     = 128;
  localparam int PNDG_OK_LIMIT = 8;
  localparam int AVL_ADDR_W    = 32;
  localparam int BURST_W       = 7;

  // one FIFO entry is {bar, sop, eop, be, data}
  localparam int FIFO_W = DATA_W + BE_W + NUM_BARS + 2;

  // avalon window of each BAR, index 0 on the right
  localparam logic [NUM_BARS-1:0][AVL_ADDR_W-1:0] BAR_BASE = {
    32'h0060_0000,
    32'h0050_0000,
    32'h0040_0000,
    32'h0030_0000,
    32'h0020_0000,
    32'h0010_0000
  };

  // PCIe offset bits kept by each BAR
  localparam logic [NUM_BARS-1:0][AVL_ADDR_W-1:0] BAR_MASK = {
    32'h0000_0FFF,
    32'h0000_FFFF,
    32'h0000_3FFF,
    32'h0000_0FFF,
    32'h000F_FFFF,
    32'h0000_FFFF
  };

  typedef enum logic [3:0] {
    IDLE,
    RD_HDR2,
    HDR_PIPE,
    CHECK_HDR,
    WR_ENA,
    WR_WAIT,
    STORE_RD,
    RD_ENA,
    DUMP
  } rx_state_e;

  typedef enum logic [3:0] {
    WRITE,
    READ,
    FLUSH,
    UNS_READ,
    MSG_WD,
    MSG_WOD,
    CPL_WD,
    DROP,
    OTHER
  } tlp_kind_e;

  typedef struct packed {
    logic        uns;
    logic [3:0]  last_be;
    logic [2:0]  tc;
    logic [1:0]  attr;
    logic [3:0]  first_be;
    logic [10:0] dw_len;
    logic [15:0] req_id;
    logic        flush;
    logic [6:0]  addr_lo;
    logic [7:0]  tag;
  } pndg_rd_hdr_t;

endpackage

//--- rtl/rx_beat_if.sv
/*
  rx_beat_if: buffered receive beats from the input FIFO to the
  header decoder and the request sequencer
*/
`timescale 1ns/1ps

interface rx_beat_if;

  logic                          not_empty;
  logic [rx_pkg::DATA_W-1:0]     data;
  logic [rx_pkg::BE_W-1:0]       be;
  logic                          sop;
  logic                          eop;
  logic [rx_pkg::NUM_BARS-1:0]   bar;
  logic [rx_pkg::FIFO_CNT_W-1:0] cnt;      // entries still in the FIFO
  logic                          rd_req;   // beat shows up one cycle later

  modport fifo (
    output not_empty, data, be, sop, eop, bar, cnt,
    input  rd_req
  );

  modport seq (
    output rd_req,
    input  cnt, not_empty, data, be, sop, eop
  );

  modport hdr (
    input data, bar
  );

endinterface

//--- rtl/rx_input_fifo.sv
/*
  rx_input_fifo: registers the receive stream and buffers beats in a
  16-entry FIFO, ready is raised from the fill level
*/
`timescale 1ns/1ps

module rx_input_fifo
(
  input  logic                        AvlClk_i,
  input  logic                        Rstn_i,
  input  logic                        st_valid_i,
  input  logic [rx_pkg::DATA_W-1:0]   st_data_i,
  input  logic [rx_pkg::BE_W-1:0]     st_be_i,
  input  logic                        st_sop_i,
  input  logic                        st_eop_i,
  input  logic [rx_pkg::NUM_BARS-1:0] st_bar_i,
  output logic                        st_ready_o,
  rx_beat_if.fifo                     beat
);

  logic                          in_vld_q;
  logic [rx_pkg::FIFO_W-1:0]     in_word_q;
  logic [rx_pkg::FIFO_W-1:0]     mem [rx_pkg::FIFO_DEPTH];
  logic [rx_pkg::FIFO_W-1:0]     rd_word_q;
  logic [rx_pkg::FIFO_CNT_W-2:0] wr_ptr_q;
  logic [rx_pkg::FIFO_CNT_W-2:0] rd_ptr_q;
  logic [rx_pkg::FIFO_CNT_W-1:0] cnt_q;

  // input capture stage
  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      in_vld_q <= 1'b0;
    else
      in_vld_q <= st_valid_i;
  end

  always_ff @(posedge AvlClk_i)
  begin
    in_word_q <= {st_bar_i, st_sop_i, st_eop_i, st_be_i, st_data_i};
    if (in_vld_q)
      mem[wr_ptr_q] <= in_word_q;
    if (beat.rd_req)
      rd_word_q <= mem[rd_ptr_q];   // no show-ahead, held until next read
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      cnt_q      <= '0;
      st_ready_o <= 1'b0;
    end
    else
    begin
      if (in_vld_q)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (beat.rd_req)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      if (in_vld_q && !beat.rd_req)
        cnt_q <= cnt_q + 1'b1;
      else if (!in_vld_q && beat.rd_req)
        cnt_q <= cnt_q - 1'b1;
      st_ready_o <= (cnt_q <= rx_pkg::READY_LIMIT);  // one cycle behind the count
    end
  end

  assign {beat.bar, beat.sop, beat.eop, beat.be, beat.data} = rd_word_q;
  assign beat.not_empty = (cnt_q != '0);
  assign beat.cnt       = cnt_q;

  // the source must honour ready within its 3-beat allowance
  a_no_overflow: assert property (@(posedge AvlClk_i) disable iff (!Rstn_i)
    in_vld_q |-> (cnt_q < rx_pkg::FIFO_DEPTH))
    else $error("input FIFO written while full");

  a_no_underflow: assert property (@(posedge AvlClk_i) disable iff (!Rstn_i)
    beat.rd_req |-> beat.not_empty)
    else $error("input FIFO read while empty");

endmodule

//--- rtl/tlp_header_decode.sv
/*
  tlp_header_decode: captures the TLP header, classifies the request
  and translates its address through the hit BAR
*/
`timescale 1ns/1ps

module tlp_header_decode
(
  input  logic                          AvlClk_i,
  input  logic                          Rstn_i,
  rx_beat_if.hdr                        beat,
  input  logic                          ld_hdr_lo_i,
  input  logic                          ld_hdr_hi_i,
  input  logic                          first_beat_done_i,
  output rx_pkg::tlp_kind_e             kind_o,
  output logic [rx_pkg::BURST_W-1:0]    qw_len_o,
  output logic [rx_pkg::AVL_ADDR_W-1:0] avl_addr_o,
  output logic [rx_pkg::BE_W-1:0]       rd_be_o,
  output logic [rx_pkg::NUM_BARS-1:0]   bar_hit_o,
  output rx_pkg::pndg_rd_hdr_t          pndg_hdr_o,
  output logic [rx_pkg::BE_W-1:0]       first_be_mask_o
);

  logic [rx_pkg::DATA_W-1:0]     hdr_lo_q;
  logic [rx_pkg::DATA_W-1:0]     hdr_hi_q;
  logic [rx_pkg::NUM_BARS-1:0]   bar_q;
  logic                          first_beat_q;
  logic                          is_4dw;
  logic                          has_data;
  logic [4:0]                    tlp_type;
  logic [9:0]                    len;
  logic [3:0]                    fbe;
  logic [3:0]                    lbe;
  logic [rx_pkg::AVL_ADDR_W-1:0] pcie_addr;
  logic                          odd_addr;
  logic                          is_rd;
  logic                          is_flush;
  logic                          is_uns;
  logic [10:0]                   qw_len_full;
  logic [rx_pkg::AVL_ADDR_W-1:0] trans_addr;

  always_ff @(posedge AvlClk_i)
  begin
    if (ld_hdr_lo_i)
      hdr_lo_q <= beat.data;
    if (ld_hdr_hi_i)
      hdr_hi_q <= beat.data;
    avl_addr_o <= {trans_addr[rx_pkg::AVL_ADDR_W-1:3], 3'b000};  // qword aligned
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      bar_q        <= '0;
      bar_hit_o    <= '0;
      first_beat_q <= 1'b0;
    end
    else
    begin
      if (ld_hdr_hi_i)
        bar_q <= beat.bar;
      bar_hit_o <= bar_q;
      // marks the first data beat of a write
      if (ld_hdr_hi_i)
        first_beat_q <= 1'b1;
      else if (first_beat_done_i)
        first_beat_q <= 1'b0;
    end
  end

  // header fields, dword 0 in the low half of each qword
  assign has_data  = hdr_lo_q[30];
  assign is_4dw    = hdr_lo_q[29];
  assign tlp_type  = hdr_lo_q[28:24];
  assign len       = hdr_lo_q[9:0];
  assign fbe       = hdr_lo_q[35:32];
  assign lbe       = hdr_lo_q[39:36];
  assign pcie_addr = is_4dw ? hdr_hi_q[63:32] : hdr_hi_q[31:0];
  assign odd_addr  = pcie_addr[2];

  assign is_rd    = !has_data && (tlp_type[4:1] == 4'b0000);  // MRd and MRdLk
  assign is_flush = is_rd && (fbe == 4'h0) && (lbe == 4'h0);
  assign is_uns   = is_rd && ((len == 10'd0) || (len > rx_pkg::MAX_RD_DW));

  always_comb
  begin
    kind_o = rx_pkg::OTHER;
    if (is_rd)
    begin
      if (is_flush)
        kind_o = rx_pkg::FLUSH;
      else if (is_uns)
        kind_o = rx_pkg::UNS_READ;
      else
        kind_o = rx_pkg::READ;
    end
    else if (has_data && (tlp_type == 5'b00000))
    begin
      if ((len == 10'd1) && (fbe == 4'h0))
        kind_o = rx_pkg::DROP;   // nothing to write
      else
        kind_o = rx_pkg::WRITE;
    end
    else if (tlp_type[4:3] == 2'b10)
    begin
      if (has_data)
        kind_o = rx_pkg::MSG_WD;
      else
        kind_o = rx_pkg::MSG_WOD;
    end
    else if (has_data && (tlp_type == 5'b01010))
      kind_o = rx_pkg::CPL_WD;
  end

  // qwords touched on the 64-bit side
  assign qw_len_full = ({1'b0, len} + {10'd0, odd_addr} + 11'd1) >> 1;
  assign qw_len_o    = qw_len_full[rx_pkg::BURST_W-1:0];

  always_comb
  begin
    trans_addr = '0;
    for (int i = 0; i < rx_pkg::NUM_BARS; i++)
    begin
      if (bar_q[i])
        trans_addr = trans_addr | (pcie_addr & rx_pkg::BAR_MASK[i]) | rx_pkg::BAR_BASE[i];
    end
  end

  always_comb
  begin
    if (qw_len_full != 11'd1)
      rd_be_o = '1;
    else if (odd_addr)
      rd_be_o = {fbe, lbe};   // first dword sits in the upper half
    else
      rd_be_o = {lbe, fbe};
  end

  // lower dword of the first beat is empty on an odd address
  assign first_be_mask_o = (first_beat_q && odd_addr) ?
                           {{(rx_pkg::BE_W/2){1'b1}}, {(rx_pkg::BE_W/2){1'b0}}} : '1;

  assign pndg_hdr_o = '{uns:      is_uns,
                        last_be:  lbe,
                        tc:       hdr_lo_q[22:20],
                        attr:     hdr_lo_q[13:12],
                        first_be: fbe,
                        dw_len:   {1'b0, len},
                        req_id:   hdr_lo_q[63:48],
                        flush:    is_flush,
                        addr_lo:  pcie_addr[6:0],
                        tag:      hdr_lo_q[47:40]};

endmodule

//--- rtl/rx_req_sequencer.sv
/*
  rx_req_sequencer: reads TLPs out of the input FIFO and turns them
  into Avalon-MM write bursts, read commands and pending-read pushes
*/
`timescale 1ns/1ps

module rx_req_sequencer
(
  input  logic                          AvlClk_i,
  input  logic                          Rstn_i,
  rx_beat_if.seq                        beat,
  input  rx_pkg::tlp_kind_e             kind_i,
  input  logic [rx_pkg::BURST_W-1:0]    qw_len_i,
  input  logic [rx_pkg::AVL_ADDR_W-1:0] avl_addr_i,
  input  logic [rx_pkg::BE_W-1:0]       rd_be_i,
  input  logic [rx_pkg::NUM_BARS-1:0]   bar_hit_i,
  input  logic [rx_pkg::BE_W-1:0]       first_be_mask_i,
  input  logic [3:0]                    pndg_used_i,
  input  logic [rx_pkg::NUM_BARS-1:0]   wait_request_i,
  output logic                          ld_hdr_lo_o,
  output logic                          ld_hdr_hi_o,
  output logic                          first_beat_done_o,
  output logic [rx_pkg::NUM_BARS-1:0]   rxm_write_o,
  output logic [rx_pkg::NUM_BARS-1:0]   rxm_read_o,
  output logic [rx_pkg::AVL_ADDR_W-1:0] rxm_addr_o,
  output logic [rx_pkg::DATA_W-1:0]     rxm_wdata_o,
  output logic [rx_pkg::BE_W-1:0]       rxm_be_o,
  output logic [rx_pkg::BURST_W-1:0]    rxm_burst_o,
  output logic                          pndg_push_o
);

  rx_pkg::rx_state_e state_q;
  rx_pkg::rx_state_e state_d;
  logic              wait_sel;
  logic              start_ok;

  assign wait_sel = |(wait_request_i & bar_hit_i);   // only the hit BAR stalls
  assign start_ok = (beat.cnt >= 2) && (pndg_used_i <= rx_pkg::PNDG_OK_LIMIT);

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      state_q <= rx_pkg::IDLE;
    else
      state_q <= state_d;
  end

  always_comb
  begin
    state_d     = state_q;
    beat.rd_req = 1'b0;
    case (state_q)
      rx_pkg::IDLE:
      begin
        if (start_ok)
        begin
          beat.rd_req = 1'b1;   // header qword 0
          state_d     = rx_pkg::RD_HDR2;
        end
      end
      rx_pkg::RD_HDR2:
      begin
        beat.rd_req = 1'b1;     // header qword 1
        state_d     = rx_pkg::HDR_PIPE;
      end
      rx_pkg::HDR_PIPE:
        state_d = rx_pkg::CHECK_HDR;
      rx_pkg::CHECK_HDR, rx_pkg::WR_WAIT:
      begin
        if ((state_q == rx_pkg::WR_WAIT) || (kind_i == rx_pkg::WRITE))
        begin
          beat.rd_req = beat.not_empty;   // fetch next data beat
          if (beat.not_empty)
            state_d = rx_pkg::WR_ENA;
          else
            state_d = rx_pkg::WR_WAIT;
        end
        else if ((kind_i == rx_pkg::READ) || (kind_i == rx_pkg::FLUSH) ||
                 (kind_i == rx_pkg::UNS_READ))
          state_d = rx_pkg::STORE_RD;
        else if (beat.eop)
          state_d = rx_pkg::IDLE;       // header-only TLP
        else
          state_d = rx_pkg::DUMP;
      end
      rx_pkg::WR_ENA:
      begin
        if (!wait_sel)
        begin
          if (beat.eop)
            state_d = rx_pkg::IDLE;
          else if (beat.not_empty)
            beat.rd_req = 1'b1;
          else
            state_d = rx_pkg::WR_WAIT;  // FIFO ran dry mid-burst
        end
      end
      rx_pkg::STORE_RD:
      begin
        if (kind_i == rx_pkg::READ)
          state_d = rx_pkg::RD_ENA;
        else
          state_d = rx_pkg::IDLE;       // flush and unsupported only queue
      end
      rx_pkg::RD_ENA:
      begin
        if (!wait_sel)
          state_d = rx_pkg::IDLE;
      end
      rx_pkg::DUMP:
      begin
        if (beat.eop)
          state_d = rx_pkg::IDLE;
        else if (beat.not_empty)
          beat.rd_req = 1'b1;
      end
      default:
        state_d = rx_pkg::IDLE;
    endcase
  end

  assign ld_hdr_lo_o       = (state_q == rx_pkg::RD_HDR2);
  assign ld_hdr_hi_o       = (state_q == rx_pkg::HDR_PIPE);
  assign first_beat_done_o = (state_q == rx_pkg::WR_ENA) && !wait_sel;

  // avalon master side, all shared fields hold while stalled
  assign rxm_write_o = (state_q == rx_pkg::WR_ENA) ? bar_hit_i : '0;
  assign rxm_read_o  = (state_q == rx_pkg::RD_ENA) ? bar_hit_i : '0;
  assign rxm_addr_o  = avl_addr_i;
  assign rxm_wdata_o = beat.data;
  assign rxm_be_o    = (state_q == rx_pkg::RD_ENA) ? rd_be_i : (beat.be & first_be_mask_i);
  assign rxm_burst_o = qw_len_i;
  assign pndg_push_o = (state_q == rx_pkg::STORE_RD);

  a_one_bar_strobe: assert property (@(posedge AvlClk_i) disable iff (!Rstn_i)
    $onehot0(rxm_write_o | rxm_read_o))
    else $error("more than one BAR strobe active");

  // the FIFO must stay aligned to TLP boundaries
  a_hdr_on_sop: assert property (@(posedge AvlClk_i) disable iff (!Rstn_i)
    (state_q == rx_pkg::RD_HDR2) |-> beat.sop)
    else $error("header read without start of packet");

endmodule

//--- rtl/rx_cntrl.sv
/*
  rx_cntrl: receive request controller of the PCIe to Avalon-MM bridge,
  input FIFO, header decoder and request sequencer
*/
`timescale 1ns/1ps

module rx_cntrl
(
  input  logic                                     AvlClk_i,
  input  logic                                     Rstn_i,
  // receive stream
  input  logic                                     RxStValid_i,
  input  logic [rx_pkg::DATA_W-1:0]                RxStData_i,
  input  logic [rx_pkg::BE_W-1:0]                  RxStBe_i,
  input  logic                                     RxStSop_i,
  input  logic                                     RxStEop_i,
  input  logic [rx_pkg::NUM_BARS-1:0]              RxStBarDec_i,
  output logic                                     RxStReady_o,
  // avalon master, one strobe pair per BAR
  output logic [rx_pkg::NUM_BARS-1:0]              RxmWrite_o,
  output logic [rx_pkg::NUM_BARS-1:0]              RxmRead_o,
  output logic [rx_pkg::AVL_ADDR_W-1:0]            RxmAddress_o,
  output logic [rx_pkg::DATA_W-1:0]                RxmWriteData_o,
  output logic [rx_pkg::BE_W-1:0]                  RxmByteEnable_o,
  output logic [rx_pkg::BURST_W-1:0]               RxmBurstCount_o,
  input  logic [rx_pkg::NUM_BARS-1:0]              RxmWaitRequest_i,
  // pending read queue
  input  logic [3:0]                               PndngRdFifoUsedW_i,
  output logic                                     PndgRdFifoWrReq_o,
  output logic [$bits(rx_pkg::pndg_rd_hdr_t)-1:0]  PndgRdHeader_o
);

  rx_pkg::tlp_kind_e             kind;
  logic [rx_pkg::BURST_W-1:0]    qw_len;
  logic [rx_pkg::AVL_ADDR_W-1:0] avl_addr;
  logic [rx_pkg::BE_W-1:0]       rd_be;
  logic [rx_pkg::NUM_BARS-1:0]   bar_hit;
  logic [rx_pkg::BE_W-1:0]       first_be_mask;
  logic                          ld_hdr_lo;
  logic                          ld_hdr_hi;
  logic                          first_beat_done;

  rx_beat_if beat_if ();

  rx_input_fifo u_fifo (
    .AvlClk_i   (AvlClk_i),
    .Rstn_i     (Rstn_i),
    .st_valid_i (RxStValid_i),
    .st_data_i  (RxStData_i),
    .st_be_i    (RxStBe_i),
    .st_sop_i   (RxStSop_i),
    .st_eop_i   (RxStEop_i),
    .st_bar_i   (RxStBarDec_i),
    .st_ready_o (RxStReady_o),
    .beat       (beat_if)
  );

  tlp_header_decode u_hdr_dec (
    .AvlClk_i          (AvlClk_i),
    .Rstn_i            (Rstn_i),
    .beat              (beat_if),
    .ld_hdr_lo_i       (ld_hdr_lo),
    .ld_hdr_hi_i       (ld_hdr_hi),
    .first_beat_done_i (first_beat_done),
    .kind_o            (kind),
    .qw_len_o          (qw_len),
    .avl_addr_o        (avl_addr),
    .rd_be_o           (rd_be),
    .bar_hit_o         (bar_hit),
    .pndg_hdr_o        (PndgRdHeader_o),   // flattened record
    .first_be_mask_o   (first_be_mask)
  );

  rx_req_sequencer u_seq (
    .AvlClk_i          (AvlClk_i),
    .Rstn_i            (Rstn_i),
    .beat              (beat_if),
    .kind_i            (kind),
    .qw_len_i          (qw_len),
    .avl_addr_i        (avl_addr),
    .rd_be_i           (rd_be),
    .bar_hit_i         (bar_hit),
    .first_be_mask_i   (first_be_mask),
    .pndg_used_i       (PndngRdFifoUsedW_i),
    .wait_request_i    (RxmWaitRequest_i),
    .ld_hdr_lo_o       (ld_hdr_lo),
    .ld_hdr_hi_o       (ld_hdr_hi),
    .first_beat_done_o (first_beat_done),
    .rxm_write_o       (RxmWrite_o),
    .rxm_read_o        (RxmRead_o),
    .rxm_addr_o        (RxmAddress_o),
    .rxm_wdata_o       (RxmWriteData_o),
    .rxm_be_o          (RxmByteEnable_o),
    .rxm_burst_o       (RxmBurstCount_o),
    .pndg_push_o       (PndgRdFifoWrReq_o)
  );

endmodule

//--- verif/tb_rx_cntrl.sv
/*
  tb_rx_cntrl: table-driven testbench of the receive request controller,
  with a random-waitrequest Avalon slave, scoreboard queues and a watchdog
*/
`timescale 1ns/1ps

module tb_rx_cntrl;

  localparam int NUM_TLP = 16;

  typedef struct {
    rx_pkg::tlp_kind_e kind;
    bit                four_dw;
    logic [31:0]       addr;
    logic [9:0]        len;
    logic [3:0]        fbe;
    logic [3:0]        lbe;
    int                bar;
    logic [7:0]        tag;
    logic [15:0]       rid;
    logic [31:0]       seed;     // data pattern, tc and attr
    bit                hold;     // sent while the pending queue is over its limit
  } tlp_t;

  typedef struct packed {
    logic [5:0]  bar;
    logic [31:0] addr;
    logic [6:0]  burst;
    logic [63:0] data;
    logic [7:0]  be;
  } avl_cmd_t;

  // kind, 4dw, address, length, first be, last be, bar, tag, requester, seed, hold
  tlp_t tlps [NUM_TLP] = '{
    '{rx_pkg::WRITE,   1'b0, 32'h0000_1000, 10'd1,   4'hF, 4'h0, 0, 8'h01, 16'h0100, 32'h1111_0a00, 1'b0},
    '{rx_pkg::WRITE,   1'b1, 32'h0000_2004, 10'd3,   4'hF, 4'hF, 1, 8'h02, 16'h0100, 32'h2222_0b00, 1'b0},
    '{rx_pkg::WRITE,   1'b0, 32'h0000_0308, 10'd8,   4'hF, 4'hF, 2, 8'h03, 16'h0100, 32'h3333_0c00, 1'b0},
    '{rx_pkg::READ,    1'b0, 32'h0000_0040, 10'd1,   4'hF, 4'h0, 3, 8'h10, 16'h0a01, 32'h0000_0013, 1'b0},
    '{rx_pkg::READ,    1'b1, 32'h0000_0104, 10'd1,   4'h3, 4'h0, 4, 8'h11, 16'h0a02, 32'h0000_0025, 1'b0},
    '{rx_pkg::READ,    1'b0, 32'h0000_0200, 10'd2,   4'hF, 4'hC, 5, 8'h12, 16'h0a03, 32'h0000_0031, 1'b0},
    '{rx_pkg::READ,    1'b0, 32'h0000_0084, 10'd2,   4'hF, 4'hF, 0, 8'h13, 16'h0a04, 32'h0000_0007, 1'b0},
    '{rx_pkg::READ,    1'b0, 32'h0000_0010, 10'd1,   4'h0, 4'h0, 1, 8'h14, 16'h0a05, 32'h0000_0012, 1'b0},
    '{rx_pkg::READ,    1'b0, 32'h0000_0020, 10'd0,   4'hF, 4'hF, 2, 8'h15, 16'h0a06, 32'h0000_0024, 1'b0},
    '{rx_pkg::READ,    1'b1, 32'h0000_002c, 10'd200, 4'hF, 4'hF, 3, 8'h16, 16'h0a07, 32'h0000_0036, 1'b0},
    '{rx_pkg::MSG_WD,  1'b1, 32'h0000_0000, 10'd2,   4'h0, 4'h0, 0, 8'h20, 16'h0b00, 32'h4444_0000, 1'b0},
    '{rx_pkg::MSG_WOD, 1'b1, 32'h0000_0000, 10'd0,   4'h0, 4'h0, 0, 8'h21, 16'h0b00, 32'h0000_0000, 1'b0},
    '{rx_pkg::CPL_WD,  1'b0, 32'h0000_0000, 10'd3,   4'hF, 4'hF, 0, 8'h22, 16'h0b00, 32'h5555_0000, 1'b0},
    '{rx_pkg::WRITE,   1'b0, 32'h0000_0400, 10'd1,   4'h0, 4'h0, 4, 8'h04, 16'h0100, 32'h6666_0000, 1'b0},
    '{rx_pkg::WRITE,   1'b1, 32'h0001_2344, 10'd8,   4'hF, 4'hF, 5, 8'h05, 16'h0100, 32'h7777_0d00, 1'b0},
    '{rx_pkg::READ,    1'b0, 32'h0000_0508, 10'd2,   4'hF, 4'hF, 4, 8'h17, 16'h0a08, 32'h0000_0015, 1'b1}
  };

  logic        AvlClk_i = 1'b0;
  logic        Rstn_i;
  logic        RxStValid_i;
  logic [63:0] RxStData_i;
  logic [7:0]  RxStBe_i;
  logic        RxStSop_i;
  logic        RxStEop_i;
  logic [5:0]  RxStBarDec_i;
  logic        RxStReady_o;
  logic [5:0]  RxmWrite_o;
  logic [5:0]  RxmRead_o;
  logic [31:0] RxmAddress_o;
  logic [63:0] RxmWriteData_o;
  logic [7:0]  RxmByteEnable_o;
  logic [6:0]  RxmBurstCount_o;
  logic [5:0]  RxmWaitRequest_i = '0;
  logic [3:0]  PndngRdFifoUsedW_i;
  logic        PndgRdFifoWrReq_o;
  logic [56:0] PndgRdHeader_o;

  avl_cmd_t             wr_exp_q[$];
  avl_cmd_t             rd_exp_q[$];
  rx_pkg::pndg_rd_hdr_t pndg_exp_q[$];
  avl_cmd_t             exp_cmd;
  rx_pkg::pndg_rd_hdr_t exp_rec;
  int                   activity;     // transfers and pushes seen so far
  bit                   ready_fell;
  int                   low_beats;    // beats sent since ready went low

  rx_cntrl u_rx_cntrl (.*);

  always #4 AvlClk_i = ~AvlClk_i;

  task automatic stop_with_failure(input string why);
    begin
      $display("%s", why);
      $display("TEST FAIL");
      $fatal(1, "run stopped at the first error");
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    begin
      if (actual !== expected)
      begin
        $display("** Error at %0d ns: %s expected 0x%0h, got 0x%0h",
                 $time, name, expected, actual);
        stop_with_failure("value mismatch");
      end
    end
  endtask

  function automatic int expected_left();
    return wr_exp_q.size() + rd_exp_q.size() + pndg_exp_q.size();
  endfunction

  // one 4-bit lane per dword that carries payload
  function automatic logic [7:0] lane_be(input int k, input logic odd, input logic [9:0] len);
    logic [7:0] be;
    int         d;
    begin
      be = '0;
      for (int j = 0; j < 2; j++)
      begin
        d = 2 * k + j - int'(odd);
        if ((d >= 0) && (d < int'(len)))
          be[4*j +: 4] = 4'hF;
      end
      return be;
    end
  endfunction

  task automatic send_beat(input logic [63:0] data, input logic [7:0] be,
                           input logic sop, input logic eop, input logic [5:0] bar);
    begin
      @(posedge AvlClk_i);
      // the beat launched on the edge ready fell is the first of three
      while (!RxStReady_o && (low_beats >= 2))
      begin
        RxStValid_i <= 1'b0;
        @(posedge AvlClk_i);
      end
      if (RxStReady_o)
        low_beats = 0;
      else
        low_beats = low_beats + 1;
      RxStValid_i  <= 1'b1;
      RxStData_i   <= data;
      RxStBe_i     <= be;
      RxStSop_i    <= sop;
      RxStEop_i    <= eop;
      RxStBarDec_i <= bar;
    end
  endtask

  task automatic go_idle();
    begin
      @(posedge AvlClk_i);
      RxStValid_i <= 1'b0;
    end
  endtask

  task automatic send_tlp(input tlp_t t);
    logic        has_data;
    logic        odd;
    logic        dropped;
    logic [4:0]  tlp_type;
    logic [31:0] dw0;
    logic [31:0] dw1;
    logic [63:0] data;
    int          qw;
    int          nbeats;
    avl_cmd_t    cmd;
    begin
      has_data = (t.kind != rx_pkg::READ) && (t.kind != rx_pkg::MSG_WOD);
      tlp_type = (t.kind == rx_pkg::CPL_WD) ? 5'b01010 :
                 (t.kind == rx_pkg::MSG_WD || t.kind == rx_pkg::MSG_WOD) ? 5'b10000 : 5'b00000;
      dropped  = (t.kind == rx_pkg::WRITE) && (t.len == 10'd1) && (t.fbe == 4'h0);
      odd      = t.addr[2];
      qw       = (int'(t.len) + int'(odd) + 1) / 2;   // qwords touched
      nbeats   = has_data ? qw : 0;
      dw0 = {1'b0, has_data, t.four_dw, tlp_type, 1'b0, t.seed[2:0], 6'd0, t.seed[5:4],
             2'd0, t.len};
      dw1 = {t.rid, t.tag, t.lbe, t.fbe};
      cmd.bar   = 6'b1 << t.bar;
      cmd.addr  = ((t.addr & rx_pkg::BAR_MASK[t.bar]) | rx_pkg::BAR_BASE[t.bar]) & 32'hFFFF_FFF8;
      cmd.burst = 7'(qw);
      if (t.kind == rx_pkg::READ)
      begin
        exp_rec = '{uns: (t.len == 10'd0) || (t.len > rx_pkg::MAX_RD_DW), last_be: t.lbe,
                    tc: t.seed[2:0], attr: t.seed[5:4], first_be: t.fbe, dw_len: {1'b0, t.len},
                    req_id: t.rid, flush: (t.fbe == 4'h0) && (t.lbe == 4'h0),
                    addr_lo: t.addr[6:0], tag: t.tag};
        pndg_exp_q.push_back(exp_rec);
        if (!exp_rec.uns && !exp_rec.flush)
        begin
          cmd.data = '0;
          if (qw != 1)
            cmd.be = 8'hFF;
          else if (odd)
            cmd.be = {t.fbe, t.lbe};
          else
            cmd.be = {t.lbe, t.fbe};
          rd_exp_q.push_back(cmd);
        end
      end
      send_beat({dw1, dw0}, 8'hFF, 1'b1, 1'b0, cmd.bar);
      send_beat(t.four_dw ? {t.addr, 32'h0} : {32'h0, t.addr}, t.four_dw ? 8'hFF : 8'h0F,
                1'b0, nbeats == 0, cmd.bar);
      for (int k = 0; k < nbeats; k++)
      begin
        data     = {t.seed ^ 32'(k), ~t.seed + 32'(k)};
        cmd.data = data;
        cmd.be   = lane_be(k, odd, t.len);
        if ((t.kind == rx_pkg::WRITE) && !dropped)
          wr_exp_q.push_back(cmd);
        send_beat(data, cmd.be, 1'b0, k == nbeats - 1, cmd.bar);
      end
    end
  endtask

  task automatic send_held(input tlp_t t);
    int snap;
    begin
      go_idle();
      while (expected_left() != 0)
        @(posedge AvlClk_i);
      repeat (16) @(posedge AvlClk_i);   // let the last TLP retire
      PndngRdFifoUsedW_i <= 4'd9;
      @(posedge AvlClk_i);
      snap = activity;
      send_tlp(t);
      go_idle();
      repeat (40) @(posedge AvlClk_i);
      check_value("activity with PndngRdFifoUsedW_i at 9", snap, activity);
      PndngRdFifoUsedW_i <= 4'd8;
    end
  endtask

  // avalon slave, each BAR stalls about one cycle in four
  always @(posedge AvlClk_i)
  begin
    for (int i = 0; i < 6; i++)
      RxmWaitRequest_i[i] <= ($urandom % 4) == 0;
  end

  always @(posedge AvlClk_i)
  begin
    if (Rstn_i)
    begin
      if (RxStValid_i && !RxStReady_o)
        ready_fell = 1'b1;
      if ((RxmWrite_o & ~RxmWaitRequest_i) != '0)
      begin
        activity = activity + 1;
        if (wr_exp_q.size() == 0)
          stop_with_failure("Avalon write transfer while no write was expected");
        else
        begin
          exp_cmd = wr_exp_q.pop_front();
          check_value("RxmWrite_o", exp_cmd.bar, RxmWrite_o);
          check_value("RxmAddress_o", exp_cmd.addr, RxmAddress_o);
          check_value("RxmBurstCount_o", exp_cmd.burst, RxmBurstCount_o);
          check_value("RxmWriteData_o", exp_cmd.data, RxmWriteData_o);
          check_value("RxmByteEnable_o", exp_cmd.be, RxmByteEnable_o);
        end
      end
      if ((RxmRead_o & ~RxmWaitRequest_i) != '0)
      begin
        activity = activity + 1;
        if (rd_exp_q.size() == 0)
          stop_with_failure("Avalon read command while no read was expected");
        else
        begin
          exp_cmd = rd_exp_q.pop_front();
          check_value("RxmRead_o", exp_cmd.bar, RxmRead_o);
          check_value("RxmAddress_o", exp_cmd.addr, RxmAddress_o);
          check_value("RxmBurstCount_o", exp_cmd.burst, RxmBurstCount_o);
          check_value("RxmByteEnable_o", exp_cmd.be, RxmByteEnable_o);
        end
      end
      if (PndgRdFifoWrReq_o)
      begin
        activity = activity + 1;
        if (pndg_exp_q.size() == 0)
          stop_with_failure("pending-read push while no record was expected");
        else
          check_value("PndgRdHeader_o", pndg_exp_q.pop_front(), PndgRdHeader_o);
      end
    end
  end

  initial
  begin
    repeat (NUM_TLP * 200) @(posedge AvlClk_i);
    stop_with_failure("watchdog expired before the table was finished");
  end

  initial
  begin
    void'($urandom(32'h7d87_2f51));
    Rstn_i             = 1'b0;
    RxStValid_i        = 1'b0;
    RxStData_i         = '0;
    RxStBe_i           = '0;
    RxStSop_i          = 1'b0;
    RxStEop_i          = 1'b0;
    RxStBarDec_i       = '0;
    PndngRdFifoUsedW_i = 4'd8;   // highest fill that still lets TLPs start
    activity           = 0;
    ready_fell         = 1'b0;
    low_beats          = 0;
    repeat (5) @(posedge AvlClk_i);
    Rstn_i <= 1'b1;
    while (!RxStReady_o)
      @(posedge AvlClk_i);
    for (int n = 0; n < NUM_TLP; n++)
    begin
      if (tlps[n].hold)
        send_held(tlps[n]);
      else
        send_tlp(tlps[n]);
    end
    go_idle();
    for (int c = 0; (c < 300) && (expected_left() != 0); c++)
      @(posedge AvlClk_i);
    repeat (20) @(posedge AvlClk_i);   // catch stray transfers
    check_value("RxStReady_o low under traffic", 1, ready_fell);
    if (expected_left() != 0)
      stop_with_failure($sformatf("%0d writes, %0d reads and %0d pending records never came",
                                  wr_exp_q.size(), rd_exp_q.size(), pndg_exp_q.size()));
    else
    begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

//--- filelist.f
rtl/rx_pkg.sv
rtl/rx_beat_if.sv
rtl/rx_input_fifo.sv
rtl/tlp_header_decode.sv
rtl/rx_req_sequencer.sv
rtl/rx_cntrl.sv
verif/tb_rx_cntrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the rx_cntrl testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_rx_cntrl -f filelist.f \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_rx_cntrl > sim.log 2>&1
cat sim.log
grep -q "TEST FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
